/* hw/adc_meter_pkg.sv */
// types and codes shared by the ADC voltmeter pipeline
// digit codes above 9 are display-only and never come out of the converter

package adc_meter_pkg;

	// one ADC reading, unsigned binary
	typedef logic [7:0] sample_t;

	// 0 to 9 decimal, 10 blank, 14 letter E
	typedef logic [3:0] bcd_digit_t;

	// active low, bit 7 decimal point, bits 6..0 segments g..a
	typedef logic [7:0] seg_code_t;

	localparam bcd_digit_t digit_blank = 4'd10;
	localparam bcd_digit_t digit_err   = 4'd14;

	// reader FSM
	typedef enum logic [2:0] {
		idle,
		start,
		addr,
		addr_ack,
		data,
		master_nack,
		stop
	} i2c_state_t;

endpackage

/* hw/i2c_adc_reader.sv */
// I2C master polling a single byte from the ADC, no clock stretching
// sda_in is sampled directly, so the bus must be synchronous enough to sys_clk
// one SCL bit takes 4 * scl_div clocks; sda is only ever pulled low
`timescale 1ns/1ps

module i2c_adc_reader import adc_meter_pkg::*; #(
	parameter logic [6:0] device_addr = 7'h48,
	parameter int         scl_div     = 4,
	parameter int         poll_gap    = 64
) (
	input  logic    sys_clk,
	input  logic    sys_rst_n,
	output logic    scl,
	output logic    sda_oe,
	input  logic    sda_in,
	output sample_t sample,
	output logic    sample_valid,
	output logic    ack_error
);

	localparam int div_w = $clog2(scl_div + 1);
	localparam int gap_w = $clog2(poll_gap + 1);

	i2c_state_t       state, state_d;
	logic [1:0]       phase, phase_d;
	logic [2:0]       bit_cnt, bit_cnt_d;
	sample_t          shift, shift_d;
	logic [div_w-1:0] div_cnt;
	logic [gap_w-1:0] gap_cnt;
	logic             tick;
	logic             read_ok;
	logic             scl_d;
	logic             oe_d;
	logic             done_ok;

	// quarter SCL period
	assign tick = (div_cnt == div_w'(scl_div - 1));

	// read finished with an acknowledged address
	assign done_ok = tick && state == stop && phase == 2'd3 && read_ok;

	always_comb begin
		state_d   = state;
		phase_d   = phase;
		bit_cnt_d = bit_cnt;
		shift_d   = shift;
		if (state == idle) begin
			if (gap_cnt == gap_w'(poll_gap - 1)) begin
				state_d = start;
				phase_d = 2'd0;
				shift_d = {device_addr, 1'b1};
			end
		end else if (tick) begin
			phase_d = phase + 2'd1;
			// data bits taken at the end of the scl high level
			if (state == data && phase == 2'd2)
				shift_d = {shift[6:0], sda_in};
			if (phase == 2'd3) begin
				case (state)
					start: begin
						state_d   = addr;
						bit_cnt_d = 3'd0;
					end
					addr: begin
						shift_d   = {shift[6:0], 1'b0};
						bit_cnt_d = bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state_d = addr_ack;
					end
					addr_ack: begin
						state_d   = read_ok ? data : stop;
						bit_cnt_d = 3'd0;
					end
					data: begin
						bit_cnt_d = bit_cnt + 3'd1;
						if (bit_cnt == 3'd7)
							state_d = master_nack;
					end
					master_nack: state_d = stop;
					default:     state_d = idle;
				endcase
			end
		end
	end

	// bus levels for the state being entered
	// phases 1 and 2 are scl high for every bit slot
	always_comb begin
		scl_d = 1'b1;
		oe_d  = 1'b0;
		case (state_d)
			start: begin
				scl_d = (phase_d != 2'd3);
				oe_d  = phase_d[1];
			end
			addr: begin
				scl_d = (phase_d == 2'd1 || phase_d == 2'd2);
				oe_d  = !shift_d[7];
			end
			addr_ack, data, master_nack: begin
				scl_d = (phase_d == 2'd1 || phase_d == 2'd2);
			end
			stop: begin
				scl_d = (phase_d != 2'd0);
				oe_d  = (phase_d != 2'd3);
			end
			default: begin
				scl_d = 1'b1;
				oe_d  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state        <= idle;
			phase        <= 2'd0;
			bit_cnt      <= 3'd0;
			div_cnt      <= '0;
			gap_cnt      <= '0;
			read_ok      <= 1'b0;
			scl          <= 1'b1;
			sda_oe       <= 1'b0;
			sample_valid <= 1'b0;
			ack_error    <= 1'b0;
		end else begin
			state   <= state_d;
			phase   <= phase_d;
			bit_cnt <= bit_cnt_d;
			scl     <= scl_d;
			sda_oe  <= oe_d;
			div_cnt <= (state == idle || tick) ? '0 : div_cnt + 1'b1;
			gap_cnt <= (state == idle) ? gap_cnt + 1'b1 : '0;
			if (tick && state == addr_ack && phase == 2'd2) begin
				read_ok <= !sda_in;
				if (sda_in)
					ack_error <= 1'b1;
			end
			sample_valid <= done_ok;
			if (done_ok)
				ack_error <= 1'b0;
		end
	end

	always_ff @(posedge sys_clk) begin
		shift <= shift_d;
		if (done_ok)
			sample <= shift;
	end

	// sda may only move under a high scl for START and STOP
	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		($past(scl) && scl && $changed(sda_oe)) |-> (state inside {start, stop}));

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		sample_valid |=> !sample_valid);

endmodule

/* hw/bin_to_bcd.sv */
// shift-and-add-three, one step per clock, bcd_valid 9 clocks after sample_valid
// a sample_valid during a running conversion is ignored
`timescale 1ns/1ps

module bin_to_bcd import adc_meter_pkg::*; (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  sample_t    sample,
	input  logic       sample_valid,
	output bcd_digit_t hundreds,
	output bcd_digit_t tens,
	output bcd_digit_t ones,
	output logic       bcd_valid
);

	sample_t     bin_q;
	logic [11:0] bcd_q;
	logic [11:0] bcd_adj;
	logic [2:0]  step;
	logic        busy;

	// add 3 to every nibble that is 5 or more
	function automatic logic [11:0] add3(input logic [11:0] v);
		logic [11:0] r;
		r = v;
		for (int i = 0; i < 3; i++) begin
			if (r[i*4 +: 4] >= 4'd5)
				r[i*4 +: 4] = r[i*4 +: 4] + 4'd3;
		end
		return r;
	endfunction

	// digits corrected before the next shift
	assign bcd_adj = add3(bcd_q);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy      <= 1'b0;
			step      <= 3'd0;
			bcd_valid <= 1'b0;
		end else begin
			bcd_valid <= busy && step == 3'd7;
			if (!busy && sample_valid) begin
				busy <= 1'b1;
				step <= 3'd0;
			end else if (busy) begin
				step <= step + 3'd1;
				if (step == 3'd7)
					busy <= 1'b0;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && sample_valid) begin
			bin_q <= sample;
			bcd_q <= '0;
		end else if (busy) begin
			bcd_q <= {bcd_adj[10:0], bin_q[7]};
			bin_q <= {bin_q[6:0], 1'b0};
		end
	end

	assign hundreds = bcd_q[11:8];
	assign tens     = bcd_q[7:4];
	assign ones     = bcd_q[3:0];

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		bcd_valid |-> (hundreds <= 4'd9 && tens <= 4'd9 && ones <= 4'd9));

endmodule

/* hw/seg_scan.sv */
// eight-position common-anode scanner, segments and selects active low
// position 0 is the ones digit; positions 3 to 7 are always blank
`timescale 1ns/1ps

module seg_scan import adc_meter_pkg::*; #(
	parameter int scan_div = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	input  bcd_digit_t hundreds,
	input  bcd_digit_t tens,
	input  bcd_digit_t ones,
	input  logic       bcd_valid,
	input  logic       ack_error,
	output seg_code_t  seg_number,
	output logic [7:0] seg_choice
);

	localparam int div_w = $clog2(scan_div + 1);

	bcd_digit_t       hund_q, tens_q, ones_q;
	bcd_digit_t       code;
	logic [div_w-1:0] div_cnt;
	logic [2:0]       pos;

	function automatic seg_code_t decode(input bcd_digit_t d);
		case (d)
			4'd0:    return 8'hc0;
			4'd1:    return 8'hf9;
			4'd2:    return 8'ha4;
			4'd3:    return 8'hb0;
			4'd4:    return 8'h99;
			4'd5:    return 8'h92;
			4'd6:    return 8'h82;
			4'd7:    return 8'hf8;
			4'd8:    return 8'h80;
			4'd9:    return 8'h90;
			4'd14:   return 8'h86;
			default: return 8'hff;
		endcase
	endfunction

	// error overrides the three value positions
	always_comb begin
		case (pos)
			3'd0:    code = ack_error ? digit_err : ones_q;
			3'd1:    code = ack_error ? digit_blank : tens_q;
			3'd2:    code = ack_error ? digit_blank : hund_q;
			default: code = digit_blank;
		endcase
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			hund_q     <= digit_blank;
			tens_q     <= digit_blank;
			ones_q     <= digit_blank;
			div_cnt    <= '0;
			pos        <= 3'd0;
			seg_number <= 8'hff;
			seg_choice <= 8'hfe;
		end else begin
			// leading zero blanking, ones always shown
			if (bcd_valid) begin
				hund_q <= (hundreds == 4'd0) ? digit_blank : hundreds;
				tens_q <= (hundreds == 4'd0 && tens == 4'd0) ? digit_blank : tens;
				ones_q <= ones;
			end
			if (div_cnt == div_w'(scan_div - 1)) begin
				div_cnt <= '0;
				pos     <= pos + 3'd1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
			seg_number <= decode(code);
			seg_choice <= ~(8'b1 << pos);
		end
	end

	assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot(~seg_choice));

endmodule

/* hw/adc_meter_top.sv */
// ADC voltmeter: I2C reader, BCD converter and display scanner in a chain
// sda needs an external pullup; scl is driven push-pull
`timescale 1ns/1ps

module adc_meter_top import adc_meter_pkg::*; #(
	parameter logic [6:0] device_addr = 7'h48,
	parameter int         scl_div     = 4,
	parameter int         poll_gap    = 64,
	parameter int         scan_div    = 16
) (
	input  logic       sys_clk,
	input  logic       sys_rst_n,
	output logic       scl,
	inout  wire        sda,
	output seg_code_t  seg_number,
	output logic [7:0] seg_choice
);

	logic       sda_oe;
	logic       sda_in;
	sample_t    sample;
	logic       sample_valid;
	logic       ack_error;
	bcd_digit_t hundreds, tens, ones;
	logic       bcd_valid;

	// open drain
	assign sda    = sda_oe ? 1'b0 : 1'bz;
	assign sda_in = sda;

	i2c_adc_reader #(
		.device_addr (device_addr),
		.scl_div     (scl_div),
		.poll_gap    (poll_gap)
	) reader_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.scl          (scl),
		.sda_oe       (sda_oe),
		.sda_in       (sda_in),
		.sample       (sample),
		.sample_valid (sample_valid),
		.ack_error    (ack_error)
	);

	bin_to_bcd bcd_i (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.sample       (sample),
		.sample_valid (sample_valid),
		.hundreds     (hundreds),
		.tens         (tens),
		.ones         (ones),
		.bcd_valid    (bcd_valid)
	);

	seg_scan #(
		.scan_div (scan_div)
	) scan_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.hundreds   (hundreds),
		.tens       (tens),
		.ones       (ones),
		.bcd_valid  (bcd_valid),
		.ack_error  (ack_error),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

/* test/i2c_adc_model.sv */
// behavioral ADC slave for one-byte reads at slave_addr, no clock stretching
// read_data and nack_mode are taken when the address byte ends
`timescale 1ns/1ps

module i2c_adc_model #(
	parameter logic [6:0] slave_addr = 7'h48
) (
	input  logic       scl,
	inout  wire        sda,
	input  logic [7:0] read_data,
	input  logic       nack_mode,
	output logic [7:0] addr_byte,
	output int         xfer_count
);

	logic       sda_low;
	logic [7:0] shreg;
	logic [7:0] tx_byte;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		sda_low    = 1'b0;
		shreg      = 8'h00;
		addr_byte  = 8'h00;
		xfer_count = 0;
		forever begin
			// START is sda falling under a high scl
			do @(negedge sda); while (scl !== 1'b1);
			for (int i = 0; i < 8; i++) begin
				@(posedge scl);
				shreg = {shreg[6:0], sda};
			end
			addr_byte = shreg;
			@(negedge scl);
			if (!nack_mode && shreg == {slave_addr, 1'b1}) begin
				tx_byte = read_data;
				// ack, then msb first, each bit set a little after scl falls
				#2 sda_low = 1'b1;
				for (int i = 7; i >= 0; i--) begin
					@(negedge scl);
					#2 sda_low = !tx_byte[i];
				end
				@(negedge scl);
				#2 sda_low = 1'b0;
			end
			// STOP is sda rising under a high scl
			do @(posedge sda); while (scl !== 1'b1);
			xfer_count = xfer_count + 1;
		end
	end

endmodule

/* test/adc_meter_tb.sv */
// testbench for adc_meter_top with a behavioral ADC slave on the I2C bus
// small dividers keep one read at about two hundred clocks
`timescale 1ns/1ps

module adc_meter_tb;

	localparam logic [6:0] device_addr   = 7'h48;
	localparam int         scl_div       = 2;
	localparam int         poll_gap      = 32;
	localparam int         scan_div      = 2;
	localparam int         read_clocks   = 80 * scl_div + poll_gap + 8;
	localparam int         read_count    = 21;
	localparam int         settle_cycles = scl_div + 16;
	localparam logic [3:0] blank_code    = 4'd10;
	localparam logic [3:0] err_code      = 4'd14;

	logic        sys_clk = 1'b0;
	logic        sys_rst_n;
	logic [7:0]  seg_number;
	logic [7:0]  seg_choice;
	logic [7:0]  read_data;
	logic        nack_mode;
	logic [7:0]  addr_byte;
	int          xfer_count;
	wire         scl;
	wire         sda;
	logic [3:0]  shown [0:7];
	logic [31:0] rnd;
	logic [7:0]  next_v;
	int          directed [0:5] = '{0, 9, 10, 99, 100, 255};
	int          value_errors = 0;
	int          other_errors = 0;
	int          last_pos = -1;
	int          cur_pos;

	pullup (sda);

	always #4 sys_clk = ~sys_clk;

	adc_meter_top #(
		.device_addr (device_addr),
		.scl_div     (scl_div),
		.poll_gap    (poll_gap),
		.scan_div    (scan_div)
	) dut_i (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.scl        (scl),
		.sda        (sda),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	i2c_adc_model #(
		.slave_addr (device_addr)
	) model_i (
		.scl        (scl),
		.sda        (sda),
		.read_data  (read_data),
		.nack_mode  (nack_mode),
		.addr_byte  (addr_byte),
		.xfer_count (xfer_count)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		return y ^ (y << 5);
	endfunction

	// biased so that one, two and three digit values all come up
	function automatic logic [7:0] pick_value(input logic [31:0] r);
		case (r[1:0])
			2'd0:    return 8'(r[15:8] % 10);
			2'd1:    return 8'(10 + r[15:8] % 90);
			default: return 8'(100 + r[15:8] % 156);
		endcase
	endfunction

	// standard active low patterns back to digit codes, 15 for anything else
	function automatic logic [3:0] pattern_to_code(input logic [7:0] pat);
		case (pat)
			8'hc0:   return 4'd0;
			8'hf9:   return 4'd1;
			8'ha4:   return 4'd2;
			8'hb0:   return 4'd3;
			8'h99:   return 4'd4;
			8'h92:   return 4'd5;
			8'h82:   return 4'd6;
			8'hf8:   return 4'd7;
			8'h80:   return 4'd8;
			8'h90:   return 4'd9;
			8'h86:   return err_code;
			8'hff:   return blank_code;
			default: return 4'd15;
		endcase
	endfunction

	function automatic int low_position(input logic [7:0] sel);
		int p;
		p = -1;
		for (int i = 0; i < 8; i++)
			if (!sel[i])
				p = i;
		return p;
	endfunction

	// position 0 is ones, leading zeros blank, E replaces the value
	function automatic logic [3:0] expected_code(input int v, input bit err, input int p);
		if (err)
			return (p == 0) ? err_code : blank_code;
		case (p)
			0:       return 4'(v % 10);
			1:       return (v < 10) ? blank_code : 4'((v / 10) % 10);
			2:       return (v < 100) ? blank_code : 4'(v / 100);
			default: return blank_code;
		endcase
	endfunction

	// one full pass over the eight positions
	task automatic capture_scan();
		int p;
		for (int i = 0; i < 8; i++)
			shown[i] = 4'd15;
		for (int n = 0; n < 8 * scan_div; n++) begin
			@(negedge sys_clk);
			p = low_position(seg_choice);
			if (p >= 0)
				shown[p] = pattern_to_code(seg_number);
		end
	endtask

	// the next read may already run, the model takes the inputs at its address end
	task automatic complete_read(input logic [7:0] v, input logic nack);
		int count_before;
		@(negedge sys_clk);
		read_data    = v;
		nack_mode    = nack;
		count_before = xfer_count;
		while (xfer_count == count_before)
			@(negedge sys_clk);
		assert (addr_byte == {device_addr, 1'b1}) else begin
			value_errors++;
			$display("Mismatch at %0t: address byte %h, expected %h",
				$time, addr_byte, {device_addr, 1'b1});
		end
	endtask

	task automatic check_display(input int v, input bit err);
		logic [3:0] want;
		repeat (settle_cycles) @(negedge sys_clk);
		capture_scan();
		for (int p = 0; p < 8; p++) begin
			want = expected_code(v, err, p);
			assert (shown[p] == want) else begin
				value_errors++;
				$display("Mismatch at %0t: value %0d position %0d shows code %0d, expected %0d",
					$time, v, p, shown[p], want);
			end
		end
	endtask

	// scan order and single active select
	always @(negedge sys_clk) begin
		if (sys_rst_n) begin
			cur_pos = low_position(seg_choice);
			assert ($onehot(~seg_choice)) else begin
				other_errors++;
				$display("seg_choice %b does not select exactly one position at %0t",
					seg_choice, $time);
			end
			if (last_pos >= 0 && cur_pos != last_pos)
				assert (cur_pos == (last_pos + 1) % 8) else begin
					other_errors++;
					$display("scan jumped from position %0d to %0d at %0t",
						last_pos, cur_pos, $time);
				end
			last_pos = cur_pos;
		end
	end

	initial begin
		sys_rst_n = 1'b0;
		read_data = 8'h00;
		nack_mode = 1'b0;
		rnd       = 32'h2770edcc;
		repeat (5) @(negedge sys_clk);
		sys_rst_n = 1'b1;
		assert (scl === 1'b1 && sda === 1'b1) else begin
			other_errors++;
			$display("bus is not idle after reset: scl %b sda %b", scl, sda);
		end
		capture_scan();
		for (int p = 0; p < 8; p++)
			assert (shown[p] == blank_code) else begin
				value_errors++;
				$display("Mismatch at %0t: position %0d shows code %0d after reset, expected blank",
					$time, p, shown[p]);
			end
		for (int i = 0; i < 6; i++) begin
			complete_read(8'(directed[i]), 1'b0);
			check_display(directed[i], 1'b0);
		end
		for (int i = 0; i < 12; i++) begin
			rnd    = xorshift32(rnd);
			next_v = pick_value(rnd);
			complete_read(next_v, 1'b0);
			check_display(next_v, 1'b0);
		end
		// missing acknowledge twice, then recovery
		complete_read(8'd77, 1'b1);
		check_display(0, 1'b1);
		complete_read(8'd200, 1'b1);
		check_display(0, 1'b1);
		complete_read(8'd42, 1'b0);
		check_display(42, 1'b0);
		$display("checks done: %0d mismatches, %0d other errors", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// all reads plus margin
	initial begin
		#((read_count + 2) * read_clocks * 8);
		$display("timeout: the reads did not complete in the expected time");
		$display("** FAIL **");
		$finish;
	end

endmodule

/* build.f */
hw/adc_meter_pkg.sv
hw/i2c_adc_reader.sv
hw/bin_to_bcd.sv
hw/seg_scan.sv
hw/adc_meter_top.sv
test/i2c_adc_model.sv
test/adc_meter_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module adc_meter_tb \
		-Mdir obj_dir -f build.f
	./obj_dir/Vadc_meter_tb > sim.log 2>&1; cat sim.log
	grep -q -x -F '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log
